/* src.f */
+incdir+sim
hdl/exu_pkg.sv
hdl/exu_alu.sv
hdl/exu_controlunit.sv
hdl/exu_lane.sv
hdl/exu_dispatch.sv
hdl/exu_retire.sv
hdl/exu_top.sv
sim/exu_tb.sv

/* sim/exu_ref_model.svh */
`ifndef EXU_REF_MODEL_SVH
`define EXU_REF_MODEL_SVH

// 16-bit fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
function automatic logic [63:0] lfsr_take(inout logic [15:0] st, input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
        fb = st[15] ^ st[13] ^ st[12] ^ st[10];
        st = {st[14:0], fb};
        v  = {v[62:0], fb};
    end
    return v;
endfunction

// expected result packet from the rv64 rules
function automatic exu_out_t exu_ref(input exu_in_t p);
    exu_out_t    o;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [63:0] a, b, imm_i, imm_s, imm_u, imm_b, imm_j, pc4, tmp;
    logic        ok, taken;
    opc   = p.inst[6:0];
    f3    = p.inst[14:12];
    f7    = p.inst[31:25];
    a     = p.rs1_val;
    b     = p.rs2_val;
    imm_i = {{52{p.inst[31]}}, p.inst[31:20]};
    imm_s = {{52{p.inst[31]}}, p.inst[31:25], p.inst[11:7]};
    imm_u = {{32{p.inst[31]}}, p.inst[31:12], 12'b0};
    imm_b = {{52{p.inst[31]}}, p.inst[7], p.inst[30:25], p.inst[11:8], 1'b0};
    imm_j = {{44{p.inst[31]}}, p.inst[19:12], p.inst[20], p.inst[30:21], 1'b0};
    pc4   = p.pc + 64'd4;
    ok    = 1'b1;
    taken = 1'b0;
    o         = '0;
    o.pc      = p.pc;
    o.rd      = p.inst[11:7];
    o.next_pc = pc4;
    case (opc)
        OP_IMM: begin
            o.rd_we = 1'b1;
            case (f3)
                3'b000: o.rd_val = a + imm_i;
                3'b011: o.rd_val = {63'd0, a < imm_i};
                3'b111: o.rd_val = a & imm_i;
                3'b101: begin
                    if (f7[6:1] == 6'b010000) o.rd_val = $signed(a) >>> p.inst[25:20];
                    else ok = 1'b0;
                end
                default: ok = 1'b0;
            endcase
        end
        OP_IMM32: begin
            tmp      = a + imm_i;
            o.rd_we  = 1'b1;
            o.rd_val = {{32{tmp[31]}}, tmp[31:0]};
            ok       = (f3 == 3'b000);
        end
        OP: begin
            o.rd_we = 1'b1;
            case ({f7, f3})
                {7'h00, 3'd0}: o.rd_val = a + b;
                {7'h20, 3'd0}: o.rd_val = a - b;
                {7'h00, 3'd1}: o.rd_val = a << b[5:0];
                {7'h00, 3'd2}: o.rd_val = {63'd0, $signed(a) < $signed(b)};
                {7'h00, 3'd3}: o.rd_val = {63'd0, a < b};
                {7'h00, 3'd4}: o.rd_val = a ^ b;
                {7'h00, 3'd5}: o.rd_val = a >> b[5:0];
                {7'h20, 3'd5}: o.rd_val = $signed(a) >>> b[5:0];
                {7'h00, 3'd6}: o.rd_val = a | b;
                {7'h00, 3'd7}: o.rd_val = a & b;
                default: ok = 1'b0;
            endcase
        end
        OP32: begin
            tmp      = a + b;
            o.rd_we  = 1'b1;
            o.rd_val = {{32{tmp[31]}}, tmp[31:0]};
            ok       = ({f7, f3} == {7'h00, 3'd0});
        end
        LUI: begin
            o.rd_we  = 1'b1;
            o.rd_val = imm_u;
        end
        AUIPC: begin
            o.rd_we  = 1'b1;
            o.rd_val = p.pc + imm_u;
        end
        JAL: begin
            o.rd_we   = 1'b1;
            o.rd_val  = pc4;
            o.next_pc = p.pc + imm_j;
        end
        JALR: begin
            o.rd_we   = 1'b1;
            o.rd_val  = pc4;
            o.next_pc = (a + imm_i) & ~64'd1;
            ok        = (f3 == 3'b000);
        end
        BRANCH: begin
            case (f3)
                3'b000: taken = (a == b);
                3'b001: taken = (a != b);
                3'b100: taken = ($signed(a) < $signed(b));
                3'b101: taken = ($signed(a) >= $signed(b));
                3'b110: taken = (a < b);
                3'b111: taken = (a >= b);
                default: ok = 1'b0;
            endcase
            if (taken) o.next_pc = p.pc + imm_b;
        end
        LOAD: begin
            o.rd_we        = 1'b1;
            o.mem_ena      = 1'b1;
            o.mem_unsigned = f3[2];
            o.mem_mask     = 4'b1000 >> f3[1:0];   // byte sits in the top bit
            o.mem_addr     = a + imm_i;
            o.mem_wdata    = b;
            ok             = (f3 != 3'b111);
        end
        STORE: begin
            o.mem_ena   = 1'b1;
            o.mem_wen   = 1'b1;
            o.mem_mask  = 4'b1000 >> f3[1:0];
            o.mem_addr  = a + imm_s;
            o.mem_wdata = b;
            ok          = !f3[2];
        end
        default: ok = 1'b0;
    endcase
    if (!ok) begin
        o         = '0;
        o.pc      = p.pc;
        o.rd      = p.inst[11:7];
        o.next_pc = pc4;
        o.inv     = 1'b1;
    end
    return o;
endfunction

`endif

/* sim/exu_tb.sv */
`timescale 1ns/1ps

module exu_tb import exu_pkg::*; ();

    logic     clk = 1'b0;
    logic     rst_n;
    logic     in_req;
    logic     in_ack;
    exu_in_t  in_pkt;
    logic     out_req;
    logic     out_ack = 1'b0;
    exu_out_t out_pkt;

    logic [15:0] stim_st = 16'd82;
    logic [15:0] ack_st  = 16'd82;
    exu_out_t    exp_q[$];
    string       name_q[$];
    int          sent = 0;
    int          recv = 0;
    int          err_cnt = 0;
    int          cycles = 0;
    int          ack_delay;
    logic        req_seen = 1'b0;
    int          t_err, t_sent;

    // funct3 of add sub and or xor slt sltu sll srl sra addw
    logic [2:0] r_f3 [11] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5, 3'd0};

    `include "exu_ref_model.svh"

    exu_top u_exu_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_req  (in_req),
        .in_ack  (in_ack),
        .in_pkt  (in_pkt),
        .out_req (out_req),
        .out_ack (out_ack),
        .out_pkt (out_pkt)
    );

    always #50 clk = ~clk;

    function automatic logic [63:0] rnd(input int n);
        return lfsr_take(stim_st, n);
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [6:0] opc, input logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [6:0] opc, input logic [4:0] rd);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    function automatic logic [31:0] r_inst(input int k, input logic [4:0] rd);
        return enc_r((k == 1 || k == 9) ? 7'h20 : 7'h00, r_f3[k], (k == 10) ? OP32 : OP, rd);
    endfunction

    // random instruction for the mixed burst
    function automatic logic [31:0] rand_mix();
        logic [2:0] kind;
        logic [2:0] f3;
        logic [4:0] rd;
        kind = 3'(rnd(3));
        rd   = 5'(rnd(5));
        f3   = 3'(rnd(3));
        case (kind)
            3'd0, 3'd1: return r_inst(int'(rnd(4) % 11), rd);
            3'd2: return enc_i(12'(rnd(12)), 3'd0, f3[0] ? OP_IMM32 : OP_IMM, rd);
            3'd3: return {20'(rnd(20)), rd, f3[0] ? LUI : AUIPC};
            3'd4: return enc_b({12'(rnd(12)), 1'b0}, (f3[2:1] == 2'b01) ? f3 | 3'b100 : f3);
            3'd5: return f3[0] ? enc_j({20'(rnd(20)), 1'b0}, rd)
                               : enc_i(12'(rnd(12)), 3'd0, JALR, rd);
            3'd6: return enc_i(12'(rnd(12)), (f3 == 3'd7) ? 3'd3 : f3, LOAD, rd);
            default: return enc_s(12'(rnd(12)), {1'b0, f3[1:0]});
        endcase
    endfunction

    // four-phase handshake on the input port
    task automatic send_pkt(input logic [31:0] inst, input logic [63:0] a,
                            input logic [63:0] b, input string name);
        exu_in_t p;
        p.pc      = rnd(62) << 2;
        p.inst    = inst;
        p.rs1_val = a;
        p.rs2_val = b;
        exp_q.push_back(exu_ref(p));
        name_q.push_back(name);
        sent++;
        in_pkt <= p;
        in_req <= 1'b1;
        @(posedge clk);
        while (!in_ack) @(posedge clk);
        in_req <= 1'b0;
        @(posedge clk);
        while (in_ack) @(posedge clk);
    endtask

    task automatic send_rand(input logic [31:0] inst, input string name);
        send_pkt(inst, rnd(64), rnd(64), name);
    endtask

    task automatic begin_test();
        t_err  = err_cnt;
        t_sent = sent;
    endtask

    task automatic end_test(input string name);
        while (exp_q.size() != 0) @(posedge clk);
        $display("%s: %0d packets, %0d errors", name, sent - t_sent, err_cnt - t_err);
    endtask

    task automatic report_err(input string tname, input string field,
                              input logic [63:0] exp_v, input logic [63:0] act_v);
        $display("** Error %s: %s expected %h, actual %h", tname, field, exp_v, act_v);
        err_cnt++;
    endtask

    task automatic check_result(input exu_out_t act);
        exu_out_t exp;
        string    nm;
        recv++;
        if (exp_q.size() == 0) begin
            $display("output packet with pc %h arrived but none was expected", act.pc);
            err_cnt++;
        end else begin
            exp = exp_q.pop_front();
            nm  = name_q.pop_front();
            if (act.pc !== exp.pc)
                report_err(nm, "pc", exp.pc, act.pc);
            if (act.rd !== exp.rd)
                report_err(nm, "rd", 64'(exp.rd), 64'(act.rd));
            if (act.rd_we !== exp.rd_we)
                report_err(nm, "rd_we", 64'(exp.rd_we), 64'(act.rd_we));
            if (act.rd_val !== exp.rd_val)
                report_err(nm, "rd_val", exp.rd_val, act.rd_val);
            if (act.next_pc !== exp.next_pc)
                report_err(nm, "next_pc", exp.next_pc, act.next_pc);
            if (act.mem_ena !== exp.mem_ena)
                report_err(nm, "mem_ena", 64'(exp.mem_ena), 64'(act.mem_ena));
            if (act.mem_wen !== exp.mem_wen)
                report_err(nm, "mem_wen", 64'(exp.mem_wen), 64'(act.mem_wen));
            if (act.mem_unsigned !== exp.mem_unsigned)
                report_err(nm, "mem_unsigned", 64'(exp.mem_unsigned), 64'(act.mem_unsigned));
            if (act.mem_mask !== exp.mem_mask)
                report_err(nm, "mem_mask", 64'(exp.mem_mask), 64'(act.mem_mask));
            if (act.mem_addr !== exp.mem_addr)
                report_err(nm, "mem_addr", exp.mem_addr, act.mem_addr);
            if (act.mem_wdata !== exp.mem_wdata)
                report_err(nm, "mem_wdata", exp.mem_wdata, act.mem_wdata);
            if (act.inv !== exp.inv)
                report_err(nm, "inv", 64'(exp.inv), 64'(act.inv));
        end
    endtask

    // compare on each rising out_req
    always @(posedge clk) begin
        if (out_req && !req_seen) begin
            check_result(out_pkt);
        end
        req_seen <= out_req;
    end

    // consumer with a random answer delay
    always begin
        @(posedge clk);
        if (out_req && !out_ack) begin
            ack_delay = int'(lfsr_take(ack_st, 3));
            repeat (ack_delay) @(posedge clk);
            out_ack <= 1'b1;
            @(posedge clk);
            while (out_req) @(posedge clk);
            out_ack <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 40 * sent + 100) begin
            $display("timeout after %0d cycles, the output port stopped answering", cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin : main
        logic [63:0] a, b, base;
        rst_n  = 1'b0;
        in_req = 1'b0;
        in_pkt = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        begin_test();
        for (int k = 0; k < 11; k++) begin
            repeat (2) send_rand(r_inst(k, 5'(rnd(5))), "rtype");
        end
        end_test("rtype");

        begin_test();
        for (int n = 0; n < 4; n++) begin
            send_rand(enc_i(12'(rnd(12)), 3'd0, OP_IMM, 5'(rnd(5))), "imm");
            send_rand(enc_i(12'(rnd(12)), 3'd3, OP_IMM, 5'(rnd(5))), "imm");
            send_rand(enc_i(12'(rnd(12)), 3'd7, OP_IMM, 5'(rnd(5))), "imm");
            send_rand(enc_i({6'b010000, 6'(rnd(6))}, 3'd5, OP_IMM, 5'(rnd(5))), "imm");
            send_rand(enc_i(12'(rnd(12)), 3'd0, OP_IMM32, 5'(rnd(5))), "imm");
            send_rand({20'(rnd(20)), 5'(rnd(5)), LUI}, "imm");
            send_rand({20'(rnd(20)), 5'(rnd(5)), AUIPC}, "imm");
        end
        end_test("imm");

        begin_test();
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                for (int r = 0; r < 4; r++) begin
                    base = rnd(40);
                    case (r)
                        0: begin
                            a = base;
                            b = base;
                        end
                        1: begin
                            a = base;
                            b = base + 64'd9;
                        end
                        2: begin
                            a = base + 64'd9;
                            b = base;
                        end
                        default: begin
                            a = ~base;   // negative vs positive
                            b = base;
                        end
                    endcase
                    send_pkt(enc_b({12'(rnd(12)), 1'b0}, 3'(f)), a, b, "ctrl");
                end
            end
        end
        repeat (3) send_rand(enc_j({20'(rnd(20)), 1'b0}, 5'(rnd(5))), "ctrl");
        repeat (3) begin
            a = rnd(64) | 64'd1;   // odd target sum
            send_pkt(enc_i({11'(rnd(11)), 1'b0}, 3'd0, JALR, 5'(rnd(5))), a, rnd(64), "ctrl");
        end
        end_test("ctrl");

        begin_test();
        for (int f = 0; f < 7; f++) begin
            repeat (2) send_rand(enc_i(12'(rnd(12)), 3'(f), LOAD, 5'(rnd(5))), "mem");
        end
        for (int f = 0; f < 4; f++) begin
            repeat (2) send_rand(enc_s(12'(rnd(12)), 3'(f)), "mem");
        end
        end_test("mem");

        begin_test();
        send_rand({25'(rnd(25)), 7'b1111111}, "invalid");
        send_rand({25'(rnd(25)), 7'b0001111}, "invalid");
        repeat (2) send_rand(enc_r(7'h20, 3'd6, OP, 5'(rnd(5))), "invalid");
        end_test("invalid");

        begin_test();
        repeat (40) send_rand(rand_mix(), "burst");
        end_test("burst");

        repeat (20) @(posedge clk);
        if (recv != sent) begin
            $display("output count %0d does not match input count %0d", recv, sent);
            err_cnt++;
        end
        $display("packets sent %0d, received %0d, errors %0d", sent, recv, err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* hdl/exu_top.sv */
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_req,
    output logic     in_ack,
    input  exu_in_t  in_pkt,
    output logic     out_req,
    input  logic     out_ack,
    output exu_out_t out_pkt
);

    exu_in_t              lane_pkt;
    logic [NUM_LANES-1:0] lane_start;
    logic [NUM_LANES-1:0] lane_busy;
    logic [NUM_LANES-1:0] lane_done;
    logic [NUM_LANES-1:0] lane_release;
    exu_out_t             lane_res [NUM_LANES];

    exu_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .in_pkt     (in_pkt),
        .lane_busy  (lane_busy),
        .lane_start (lane_start),
        .lane_pkt   (lane_pkt)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        exu_lane u_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .start (lane_start[i]),
            .pkt   (lane_pkt),
            .free  (lane_release[i]),
            .busy  (lane_busy[i]),
            .done  (lane_done[i]),
            .res   (lane_res[i])
        );
    end

    exu_retire u_retire (
        .clk          (clk),
        .rst_n        (rst_n),
        .lane_done    (lane_done),
        .lane_res     (lane_res),
        .lane_release (lane_release),
        .out_req      (out_req),
        .out_ack      (out_ack),
        .out_pkt      (out_pkt)
    );

endmodule

/* hdl/exu_retire.sv */
`timescale 1ns/1ps

module exu_retire import exu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_LANES-1:0] lane_done,
    input  exu_out_t             lane_res [NUM_LANES],
    output logic [NUM_LANES-1:0] lane_release,
    output logic                 out_req,
    input  logic                 out_ack,
    output exu_out_t             out_pkt
);

    logic [LANE_IDX_W-1:0] ptr;
    logic                  fire;
    logic                  acked;

    // previous handshake must be fully closed
    assign fire  = lane_done[ptr] & ~out_req & ~out_ack;
    assign acked = out_req & out_ack;

    always_comb begin
        lane_release      = '0;
        lane_release[ptr] = acked;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_req <= 1'b0;
            ptr     <= '0;
        end else begin
            if (fire) begin
                out_req <= 1'b1;
            end else if (acked) begin
                out_req <= 1'b0;
                ptr     <= next_lane(ptr);
            end
        end
    end

    // copy so the lane can be reused while out_pkt is held
    always_ff @(posedge clk) begin
        if (fire) begin
            out_pkt <= lane_res[ptr];
        end
    end

endmodule

/* hdl/exu_dispatch.sv */
`timescale 1ns/1ps

module exu_dispatch import exu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_req,
    output logic                 in_ack,
    input  exu_in_t              in_pkt,
    input  logic [NUM_LANES-1:0] lane_busy,
    output logic [NUM_LANES-1:0] lane_start,
    output exu_in_t              lane_pkt
);

    logic [LANE_IDX_W-1:0] ptr;
    logic                  take;

    // next lane in order must be free, else in_ack is held back
    assign take = in_req & ~in_ack & ~lane_busy[ptr];

    always_comb begin
        lane_start      = '0;
        lane_start[ptr] = take;
    end

    // packet is stable while in_req is high
    assign lane_pkt = in_pkt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ack <= 1'b0;
            ptr    <= '0;
        end else begin
            if (take) begin
                in_ack <= 1'b1;
                ptr    <= next_lane(ptr);
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;   // return to idle
            end
        end
    end

endmodule

/* hdl/exu_lane.sv */
`timescale 1ns/1ps

module exu_lane import exu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  exu_in_t  pkt,
    input  logic     free,
    output logic     busy,
    output logic     done,
    output exu_out_t res
);

    exu_in_t         pkt_q;
    logic            pend;   // packet held, result not yet registered
    exu_ctrl_t       ctrl;
    logic [31:0]     inst;
    logic [XLEN-1:0] imm_i, imm_s, imm_u, imm_bj;
    logic [XLEN-1:0] src1, src2, alu_res;
    logic [XLEN-1:0] pc_plus4, jalr_sum, jump_tgt, next_pc;
    logic            lt, ltu, eq, less, taken;
    exu_out_t        res_d;

    assign inst = pkt_q.inst;

    exu_controlunit u_ctrl (
        .opcode (inst[6:0]),
        .funct3 (inst[14:12]),
        .funct7 (inst[31:25]),
        .ctrl   (ctrl)
    );

    assign imm_i  = {{52{inst[31]}}, inst[31:20]};
    assign imm_s  = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u  = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_bj = ctrl.sel_nextpc[NPC_JAL]
                  ? {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}
                  : {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    assign src1 = ({XLEN{ctrl.sel_alusrc1[SRC1_PC]}}  & pkt_q.pc)
                | ({XLEN{ctrl.sel_alusrc1[SRC1_RS1]}} & pkt_q.rs1_val);
    assign src2 = ({XLEN{ctrl.sel_alusrc2[SRC2_RS2]}}  & pkt_q.rs2_val)
                | ({XLEN{ctrl.sel_alusrc2[SRC2_IMMI]}} & imm_i)
                | ({XLEN{ctrl.sel_alusrc2[SRC2_IMMU]}} & imm_u)
                | ({XLEN{ctrl.sel_alusrc2[SRC2_FOUR]}} & XLEN'(4))
                | ({XLEN{ctrl.sel_alusrc2[SRC2_IMMS]}} & imm_s);

    exu_alu u_alu (
        .alu_op (ctrl.alu_op),
        .word   (ctrl.sel_alures[1]),
        .src1   (src1),
        .src2   (src2),
        .res    (alu_res),
        .lt     (lt),
        .ltu    (ltu),
        .eq     (eq)
    );

    // unsigned branches are marked by the sltu op
    assign less  = ctrl.alu_op[ALU_SLTU] ? ltu : lt;
    assign taken = (ctrl.sel_nextpc[NPC_BEQ] & eq)
                 | (ctrl.sel_nextpc[NPC_BNE] & ~eq)
                 | (ctrl.sel_nextpc[NPC_BLT] & less)
                 | (ctrl.sel_nextpc[NPC_BGE] & ~less);

    assign pc_plus4 = pkt_q.pc + XLEN'(4);
    assign jalr_sum = pkt_q.rs1_val + imm_i;
    assign jump_tgt = pkt_q.pc + imm_bj;
    assign next_pc  = ctrl.sel_nextpc[NPC_JALR] ? {jalr_sum[XLEN-1:1], 1'b0}
                    : (ctrl.sel_nextpc[NPC_JAL] | taken) ? jump_tgt
                    : pc_plus4;

    always_comb begin
        res_d.pc           = pkt_q.pc;
        res_d.rd           = inst[11:7];
        res_d.rd_we        = ctrl.rf_we;
        res_d.rd_val       = ctrl.sel_rfres[0] ? alu_res : '0;   // link is pc + 4 from the alu
        res_d.next_pc      = next_pc;
        res_d.mem_ena      = ctrl.mem_ena;
        res_d.mem_wen      = ctrl.mem_wen;
        res_d.mem_unsigned = ctrl.sel_rfres[2];
        res_d.mem_mask     = ctrl.mem_mask;
        res_d.mem_addr     = ctrl.mem_ena ? alu_res : '0;
        res_d.mem_wdata    = ctrl.mem_ena ? pkt_q.rs2_val : '0;
        res_d.inv          = ctrl.inv;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            pend <= 1'b0;
            done <= 1'b0;
        end else begin
            if (start) begin
                busy <= 1'b1;
                pend <= 1'b1;
            end else if (pend) begin
                pend <= 1'b0;
                done <= 1'b1;
            end
            if (free) begin
                busy <= 1'b0;
                done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            pkt_q <= pkt;
        end
        if (pend) begin
            res <= res_d;
        end
    end

endmodule

/* hdl/exu_controlunit.sv */
`timescale 1ns/1ps

module exu_controlunit import exu_pkg::*; (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    output exu_ctrl_t  ctrl
);

    logic op_imm, op_imm32, op_reg, op_reg32, op_branch, op_load, op_store;
    logic f7_zero, f7_alt;

    logic i_addi, i_sltiu, i_andi, i_srai, i_addiw;
    logic i_lui, i_auipc, i_jal, i_jalr;
    logic i_add, i_sub, i_and, i_or, i_xor, i_slt, i_sltu, i_sll, i_srl, i_sra, i_addw;
    logic i_beq, i_bne, i_blt, i_bge, i_bltu, i_bgeu;
    logic i_ld, i_lw, i_lh, i_lb, i_lwu, i_lhu, i_lbu;
    logic i_sd, i_sw, i_sh, i_sb;

    logic r_type, b_type, imm_alu, load, store, word_op, wb;

    assign op_imm    = (opcode == OP_IMM);
    assign op_imm32  = (opcode == OP_IMM32);
    assign op_reg    = (opcode == OP);
    assign op_reg32  = (opcode == OP32);
    assign op_branch = (opcode == BRANCH);
    assign op_load   = (opcode == LOAD);
    assign op_store  = (opcode == STORE);
    assign f7_zero   = (funct7 == 7'b0000000);
    assign f7_alt    = (funct7 == 7'b0100000);

    assign i_addi  = op_imm && (funct3 == 3'b000);
    assign i_sltiu = op_imm && (funct3 == 3'b011);
    assign i_andi  = op_imm && (funct3 == 3'b111);
    // funct7[0] is shamt[5] on rv64
    assign i_srai  = op_imm && (funct3 == 3'b101) && (funct7[6:1] == 6'b010000);
    assign i_addiw = op_imm32 && (funct3 == 3'b000);

    assign i_lui   = (opcode == LUI);
    assign i_auipc = (opcode == AUIPC);
    assign i_jal   = (opcode == JAL);
    assign i_jalr  = (opcode == JALR) && (funct3 == 3'b000);

    assign i_add  = op_reg && (funct3 == 3'b000) && f7_zero;
    assign i_sub  = op_reg && (funct3 == 3'b000) && f7_alt;
    assign i_sll  = op_reg && (funct3 == 3'b001) && f7_zero;
    assign i_slt  = op_reg && (funct3 == 3'b010) && f7_zero;
    assign i_sltu = op_reg && (funct3 == 3'b011) && f7_zero;
    assign i_xor  = op_reg && (funct3 == 3'b100) && f7_zero;
    assign i_srl  = op_reg && (funct3 == 3'b101) && f7_zero;
    assign i_sra  = op_reg && (funct3 == 3'b101) && f7_alt;
    assign i_or   = op_reg && (funct3 == 3'b110) && f7_zero;
    assign i_and  = op_reg && (funct3 == 3'b111) && f7_zero;
    assign i_addw = op_reg32 && (funct3 == 3'b000) && f7_zero;

    assign i_beq  = op_branch && (funct3 == 3'b000);
    assign i_bne  = op_branch && (funct3 == 3'b001);
    assign i_blt  = op_branch && (funct3 == 3'b100);
    assign i_bge  = op_branch && (funct3 == 3'b101);
    assign i_bltu = op_branch && (funct3 == 3'b110);
    assign i_bgeu = op_branch && (funct3 == 3'b111);

    assign i_lb  = op_load && (funct3 == 3'b000);
    assign i_lh  = op_load && (funct3 == 3'b001);
    assign i_lw  = op_load && (funct3 == 3'b010);
    assign i_ld  = op_load && (funct3 == 3'b011);
    assign i_lbu = op_load && (funct3 == 3'b100);
    assign i_lhu = op_load && (funct3 == 3'b101);
    assign i_lwu = op_load && (funct3 == 3'b110);

    assign i_sb = op_store && (funct3 == 3'b000);
    assign i_sh = op_store && (funct3 == 3'b001);
    assign i_sw = op_store && (funct3 == 3'b010);
    assign i_sd = op_store && (funct3 == 3'b011);

    assign r_type  = i_add | i_sub | i_and | i_or | i_xor | i_slt | i_sltu
                   | i_sll | i_srl | i_sra | i_addw;
    assign b_type  = i_beq | i_bne | i_blt | i_bge | i_bltu | i_bgeu;
    assign imm_alu = i_addi | i_sltiu | i_andi | i_srai | i_addiw;
    assign load    = i_ld | i_lw | i_lh | i_lb | i_lwu | i_lhu | i_lbu;
    assign store   = i_sd | i_sw | i_sh | i_sb;
    assign word_op = i_addw | i_addiw;
    assign wb      = imm_alu | r_type | i_lui | i_auipc | i_jal | i_jalr | load;

    assign ctrl.alu_op = {
        i_lui,
        i_sra | i_srai,
        i_srl,
        i_sll,
        i_xor,
        i_or,
        i_and | i_andi,
        i_sltu | i_sltiu | i_bltu | i_bgeu,
        i_slt | i_blt | i_bge,
        i_sub | i_beq | i_bne,
        i_add | i_addi | i_addw | i_addiw | i_auipc | i_jal | i_jalr | load | store
    };

    assign ctrl.rf_we       = wb;
    assign ctrl.sel_alusrc1 = {i_auipc | i_jal | i_jalr,
                               imm_alu | r_type | b_type | load | store};
    assign ctrl.sel_alusrc2 = {store,
                               i_jal | i_jalr,       // link is pc + 4
                               i_lui | i_auipc,
                               imm_alu | load,
                               r_type | b_type};
    assign ctrl.sel_nextpc  = {i_bge | i_bgeu,
                               i_blt | i_bltu,
                               i_bne,
                               i_beq,
                               i_jalr,
                               i_jal,
                               imm_alu | r_type | i_lui | i_auipc | load | store};
    assign ctrl.sel_rfres   = {i_lwu | i_lhu | i_lbu,
                               i_ld | i_lw | i_lh | i_lb,
                               wb & ~load};
    assign ctrl.mem_ena     = load | store;
    assign ctrl.mem_wen     = store;
    assign ctrl.mem_mask    = {i_lb | i_lbu | i_sb,
                               i_lh | i_lhu | i_sh,
                               i_lw | i_lwu | i_sw,
                               i_ld | i_sd};
    assign ctrl.inv         = ~(wb | b_type | store);
    assign ctrl.sel_alures  = {word_op, ~word_op};

endmodule

/* hdl/exu_alu.sv */
`timescale 1ns/1ps

module exu_alu import exu_pkg::*; (
    input  logic [ALU_OPS-1:0] alu_op,
    input  logic               word,
    input  logic [XLEN-1:0]    src1,
    input  logic [XLEN-1:0]    src2,
    output logic [XLEN-1:0]    res,
    output logic               lt,
    output logic               ltu,
    output logic               eq
);

    logic [XLEN-1:0] sum, diff, sll_res, srl_res, sra_res, raw;
    logic [XLEN-1:0] srl_src, sra_src;
    logic [5:0]      shamt;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    assign lt  = $signed(src1) < $signed(src2);
    assign ltu = src1 < src2;
    assign eq  = (src1 == src2);

    // word shifts act on the low half only
    assign shamt   = word ? {1'b0, src2[4:0]} : src2[5:0];
    assign srl_src = word ? {32'b0, src1[31:0]} : src1;
    assign sra_src = word ? {{32{src1[31]}}, src1[31:0]} : src1;

    assign sll_res = src1 << shamt;
    assign srl_res = srl_src >> shamt;
    assign sra_res = $signed(sra_src) >>> shamt;

    always_comb begin
        raw = ({XLEN{alu_op[ALU_ADD]}}  & sum)
            | ({XLEN{alu_op[ALU_SUB]}}  & diff)
            | ({XLEN{alu_op[ALU_SLT]}}  & XLEN'(lt))
            | ({XLEN{alu_op[ALU_SLTU]}} & XLEN'(ltu))
            | ({XLEN{alu_op[ALU_AND]}}  & (src1 & src2))
            | ({XLEN{alu_op[ALU_OR]}}   & (src1 | src2))
            | ({XLEN{alu_op[ALU_XOR]}}  & (src1 ^ src2))
            | ({XLEN{alu_op[ALU_SLL]}}  & sll_res)
            | ({XLEN{alu_op[ALU_SRL]}}  & srl_res)
            | ({XLEN{alu_op[ALU_SRA]}}  & sra_res)
            | ({XLEN{alu_op[ALU_LUI]}}  & src2);   // immU passes straight through
    end

    assign res = word ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

/* hdl/exu_pkg.sv */
package exu_pkg;

    localparam int XLEN       = 64;
    localparam int NUM_LANES  = 4;   // 2 and 8 work as well
    localparam int LANE_IDX_W = $clog2(NUM_LANES);

    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_IMM32 = 7'b0011011;
    localparam logic [6:0] OP       = 7'b0110011;
    localparam logic [6:0] OP32     = 7'b0111011;
    localparam logic [6:0] LUI      = 7'b0110111;
    localparam logic [6:0] AUIPC    = 7'b0010111;
    localparam logic [6:0] JAL      = 7'b1101111;
    localparam logic [6:0] JALR     = 7'b1100111;
    localparam logic [6:0] BRANCH   = 7'b1100011;
    localparam logic [6:0] LOAD     = 7'b0000011;
    localparam logic [6:0] STORE    = 7'b0100011;

    // bit positions inside the one-hot alu_op
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_OR   = 5;
    localparam int ALU_XOR  = 6;
    localparam int ALU_SLL  = 7;
    localparam int ALU_SRL  = 8;
    localparam int ALU_SRA  = 9;
    localparam int ALU_LUI  = 10;
    localparam int ALU_OPS  = 11;

    localparam int SRC1_RS1 = 0;
    localparam int SRC1_PC  = 1;

    localparam int SRC2_RS2  = 0;
    localparam int SRC2_IMMI = 1;
    localparam int SRC2_IMMU = 2;
    localparam int SRC2_FOUR = 3;
    localparam int SRC2_IMMS = 4;

    localparam int NPC_SEQ  = 0;
    localparam int NPC_JAL  = 1;
    localparam int NPC_JALR = 2;
    localparam int NPC_BEQ  = 3;
    localparam int NPC_BNE  = 4;
    localparam int NPC_BLT  = 5;   // blt and bltu
    localparam int NPC_BGE  = 6;   // bge and bgeu

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
    } exu_in_t;

    typedef struct packed {
        logic [ALU_OPS-1:0] alu_op;
        logic               rf_we;
        logic [1:0]         sel_alusrc1;
        logic [4:0]         sel_alusrc2;
        logic [6:0]         sel_nextpc;
        logic [2:0]         sel_rfres;   // unsigned load, signed load, alu
        logic               mem_ena;
        logic               mem_wen;
        logic [3:0]         mem_mask;    // byte, half, word, dword
        logic               inv;
        logic [1:0]         sel_alures;  // word, full
    } exu_ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic            rd_we;
        logic [XLEN-1:0] rd_val;
        logic [XLEN-1:0] next_pc;
        logic            mem_ena;
        logic            mem_wen;
        logic            mem_unsigned;
        logic [3:0]      mem_mask;
        logic [XLEN-1:0] mem_addr;
        logic [XLEN-1:0] mem_wdata;
        logic            inv;
    } exu_out_t;

    // round-robin step shared by dispatch and retire
    function automatic logic [LANE_IDX_W-1:0] next_lane(input logic [LANE_IDX_W-1:0] idx);
        if (idx == LANE_IDX_W'(NUM_LANES - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

endpackage
